// File: design/apogeo_params.svh
`ifndef APOGEO_PARAMS_SVH
`define APOGEO_PARAMS_SVH

// Set to 0 to build the decode block without the Zbb decoder
`define BMU 1

// Width of every data word in the core
`define XLEN 32

// Exception vector codes reported to the reorder buffer
`define INSTR_ILLEGAL 5'd2
`define ECALL_U 5'd8
`define ECALL_M 5'd11

// Distance from a jump to the instruction that follows it
`define LINK_OFFSET 4

`endif

// File: design/apogeo_pkg.sv
`include "apogeo_params.svh"

package apogeo_pkg;

    // ==============================
    // Basic words
    // ==============================

    typedef logic [`XLEN-1:0] data_word_t;
    typedef logic [4:0] reg_addr_t;

    // Major opcodes of the supported RV32 subset
    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_t;

    // ==============================
    // Unit operations
    // ==============================

    // ADD must stay at zero so that an empty micro-operation is an ALU add
    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_t;

    typedef enum logic [3:0] {
        ANDN, ORN, XNOR, CLZ, CTZ, CPOP, MIN, MAX, MINU, MAXU
    } bmu_op_t;

    typedef enum logic {
        CSRRW, CSRRS
    } csr_op_t;

    // One select per execution unit, at most one of them set
    typedef struct packed {
        logic alu;
        logic bmu;
        logic load;
        logic store;
        logic branch;
        logic jump;
        logic csr;
    } exu_valid_t;

    // Only the field of the selected unit carries an operation
    typedef struct packed {
        alu_op_t alu_op;
        bmu_op_t bmu_op;
        csr_op_t csr_op;
    } exu_uop_t;

    // ==============================
    // Packets
    // ==============================

    // Combinational result of the decoder
    typedef struct packed {
        reg_addr_t [1:0]  reg_src;
        reg_addr_t        reg_dest;
        data_word_t [1:0] immediate;
        logic [1:0]       immediate_valid;
        logic             base_address_reg;
        data_word_t       address_offset;
        logic             save_next_pc;
        logic             fence;
        exu_valid_t       exu_valid;
        exu_uop_t         exu_uop;
        logic             exception_generated;
        logic [4:0]       exception_vector;
    } decode_packet_t;

    // Registered packet handed to issue, with the resolved addresses
    typedef struct packed {
        decode_packet_t decode;
        data_word_t     pc;
        data_word_t     target;
        data_word_t     link;
    } issue_packet_t;

endpackage

// File: design/integer_decoder.sv
`timescale 1ns/1ps
`include "apogeo_params.svh"

module integer_decoder import apogeo_pkg::*; (
    input  data_word_t     instr_i,
    input  logic           priv_level_i,
    output decode_packet_t packet_o,
    output logic           accept_o
);

    // Instruction fields at their fixed RV32 positions
    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;

    // Sign-extended immediates of every format
    data_word_t imm_i;
    data_word_t imm_s;
    data_word_t imm_b;
    data_word_t imm_u;
    data_word_t imm_j;

    // Qualifiers shared by the OP and OP-IMM rows
    logic f7_zero;
    logic f7_alt;
    logic is_shift;
    logic is_ecall;

    assign opcode = opcode_t'(instr_i[6:0]);
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign funct7 = instr_i[31:25];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    assign f7_zero  = funct7 == 7'b0000000;
    assign f7_alt   = funct7 == 7'b0100000;
    assign is_shift = funct3 == 3'b001 || funct3 == 3'b101;

    // The alternate funct7 turns ADD into SUB and SRL into SRA
    function automatic alu_op_t alu_op_of(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    // ==============================
    // Opcode table
    // ==============================

    always_comb begin
        packet_o = '0;
        accept_o = 1'b0;
        is_ecall = 1'b0;

        case (opcode)
            OPC_OP: begin
                // Only ADD and SRL have an alternate encoding
                if (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    accept_o = 1'b1;
                    packet_o.exu_valid.alu = 1'b1;
                    packet_o.exu_uop.alu_op = alu_op_of(funct3, f7_alt);
                    packet_o.reg_src[0] = rs1;
                    packet_o.reg_src[1] = rs2;
                    packet_o.reg_dest = rd;
                end
            end

            OPC_OP_IMM: begin
                if (!is_shift || f7_zero || (f7_alt && funct3 == 3'b101)) begin
                    accept_o = 1'b1;
                    packet_o.exu_valid.alu = 1'b1;
                    packet_o.exu_uop.alu_op = alu_op_of(funct3, is_shift && f7_alt);
                    packet_o.reg_src[0] = rs1;
                    packet_o.reg_dest = rd;
                    // Shifts only carry the shift amount in the rs2 slot
                    packet_o.immediate[0] = is_shift ? data_word_t'(rs2) : imm_i;
                    packet_o.immediate_valid = 2'b01;
                end
            end

            OPC_LUI, OPC_AUIPC: begin
                // LUI adds the upper immediate to x0
                accept_o = 1'b1;
                packet_o.exu_valid.alu = 1'b1;
                packet_o.exu_uop.alu_op = ADD;
                packet_o.reg_dest = rd;
                packet_o.immediate[0] = imm_u;
                packet_o.immediate_valid = 2'b01;
                // AUIPC gets pc plus the immediate on the issue target
                if (opcode == OPC_AUIPC) begin
                    packet_o.address_offset = imm_u;
                end
            end

            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    accept_o = 1'b1;
                    packet_o.exu_valid.load = 1'b1;
                    packet_o.reg_src[0] = rs1;
                    packet_o.reg_dest = rd;
                    packet_o.immediate[0] = imm_i;
                    packet_o.immediate_valid = 2'b01;
                end
            end

            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    accept_o = 1'b1;
                    packet_o.exu_valid.store = 1'b1;
                    packet_o.reg_src[0] = rs1;
                    packet_o.reg_src[1] = rs2;
                    packet_o.immediate[1] = imm_s;
                    packet_o.immediate_valid = 2'b10;
                end
            end

            OPC_BRANCH: begin
                // BEQ and BNE only
                if (funct3[2:1] == 2'b00) begin
                    accept_o = 1'b1;
                    packet_o.exu_valid.branch = 1'b1;
                    packet_o.reg_src[0] = rs1;
                    packet_o.reg_src[1] = rs2;
                    packet_o.immediate[1] = imm_b;
                    packet_o.immediate_valid = 2'b10;
                    packet_o.address_offset = imm_b;
                end
            end

            OPC_JAL: begin
                accept_o = 1'b1;
                packet_o.exu_valid.jump = 1'b1;
                packet_o.reg_dest = rd;
                packet_o.save_next_pc = 1'b1;
                packet_o.address_offset = imm_j;
            end

            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    accept_o = 1'b1;
                    packet_o.exu_valid.jump = 1'b1;
                    packet_o.reg_src[0] = rs1;
                    packet_o.reg_dest = rd;
                    packet_o.save_next_pc = 1'b1;
                    packet_o.base_address_reg = 1'b1;
                    packet_o.address_offset = imm_i;
                end
            end

            OPC_MISC_MEM: begin
                // FENCE needs no unit, it only orders memory
                if (funct3 == 3'b000) begin
                    accept_o = 1'b1;
                    packet_o.fence = 1'b1;
                end
            end

            OPC_SYSTEM: begin
                if (funct3 == 3'b000 && instr_i[31:7] == '0) begin
                    is_ecall = 1'b1;
                end else if (funct3 == 3'b001 || funct3 == 3'b010) begin
                    accept_o = 1'b1;
                    packet_o.exu_valid.csr = 1'b1;
                    packet_o.exu_uop.csr_op = funct3[1] ? CSRRS : CSRRW;
                    packet_o.reg_src[0] = rs1;
                    packet_o.reg_dest = rd;
                    // The CSR address rides in the first immediate
                    packet_o.immediate[0] = {20'b0, instr_i[31:20]};
                    packet_o.immediate_valid = 2'b01;
                end
            end

            default: ;
        endcase

        // ECALL is rejected too, but with a vector chosen by privilege
        if (!accept_o) begin
            packet_o.exception_generated = 1'b1;
            packet_o.exception_vector = is_ecall ? (priv_level_i ? `ECALL_M : `ECALL_U)
                                                 : `INSTR_ILLEGAL;
        end
    end

    // A word never reaches two execution units at once
    always_comb begin : chk_unit_select
        assert final ($onehot0(packet_o.exu_valid))
            else $error("integer decoder selected more than one unit");
    end

endmodule

// File: design/bit_manipulation_decoder.sv
`timescale 1ns/1ps
`include "apogeo_params.svh"

module bit_manipulation_decoder import apogeo_pkg::*; (
    input  data_word_t     instr_i,
    output decode_packet_t packet_o,
    output logic           accept_o
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rs2;
    bmu_op_t    op;
    logic       unary;

    assign opcode = opcode_t'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign rs2    = instr_i[24:20];
    assign funct7 = instr_i[31:25];

    always_comb begin
        packet_o = '0;
        accept_o = 1'b0;
        unary    = 1'b0;
        op       = ANDN;

        if (opcode == OPC_OP && funct7 == 7'b0100000) begin
            // Logic with an inverted second operand
            accept_o = 1'b1;
            case (funct3)
                3'b111:  op = ANDN;
                3'b110:  op = ORN;
                3'b100:  op = XNOR;
                default: accept_o = 1'b0;
            endcase
        end else if (opcode == OPC_OP && funct7 == 7'b0000101) begin
            // Min and max sit in the upper half of funct3
            accept_o = funct3[2];
            case (funct3[1:0])
                2'b00:   op = MIN;
                2'b01:   op = MINU;
                2'b10:   op = MAX;
                default: op = MAXU;
            endcase
        end else if (opcode == OPC_OP_IMM && funct7 == 7'b0110000 && funct3 == 3'b001) begin
            // Counting ops pick the operation from the rs2 field
            accept_o = 1'b1;
            unary = 1'b1;
            case (rs2)
                5'd0:    op = CLZ;
                5'd1:    op = CTZ;
                5'd2:    op = CPOP;
                default: accept_o = 1'b0;
            endcase
        end

        if (accept_o) begin
            packet_o.exu_valid.bmu = 1'b1;
            packet_o.exu_uop.bmu_op = op;
            packet_o.reg_src[0] = instr_i[19:15];
            packet_o.reg_src[1] = unary ? '0 : rs2;
            packet_o.reg_dest = instr_i[11:7];
        end else begin
            packet_o.exception_generated = 1'b1;
            packet_o.exception_vector = `INSTR_ILLEGAL;
        end
    end

endmodule

// File: design/decoder.sv
`timescale 1ns/1ps
`include "apogeo_params.svh"

module decoder import apogeo_pkg::*; (
    input  data_word_t     instr_i,
    input  logic           priv_level_i,
    output decode_packet_t packet_o
);

    decode_packet_t int_packet;
    decode_packet_t bmu_packet;
    logic           int_accept;
    logic           bmu_accept;

    // ==============================
    // Decoders
    // ==============================

    integer_decoder u_integer_decoder (
        .instr_i      ( instr_i      ),
        .priv_level_i ( priv_level_i ),
        .packet_o     ( int_packet   ),
        .accept_o     ( int_accept   )
    );

    // Without the Zbb decoder every Zbb word falls through as illegal
    if (`BMU != 0) begin : gen_bmu
        bit_manipulation_decoder u_bit_manipulation_decoder (
            .instr_i  ( instr_i    ),
            .packet_o ( bmu_packet ),
            .accept_o ( bmu_accept )
        );
    end else begin : gen_no_bmu
        assign bmu_packet = '0;
        assign bmu_accept = 1'b0;
    end

    // ==============================
    // Merge
    // ==============================

    always_comb begin
        case ({int_accept, bmu_accept})
            2'b10: begin
                packet_o = int_packet;
            end

            2'b01: begin
                // The Zbb ops never use a second immediate
                packet_o = bmu_packet;
                packet_o.immediate[1] = '0;
                packet_o.immediate_valid[1] = 1'b0;
            end

            default: begin
                // Nobody owns the word so an ADD bubble carries the exception
                packet_o = '0;
                packet_o.exu_valid.alu = 1'b1;
                packet_o.exu_uop.alu_op = ADD;
                packet_o.exception_generated = 1'b1;
                // The integer vector tells ECALL apart from a bad encoding
                packet_o.exception_vector = int_packet.exception_vector;
            end
        endcase
    end

    // The two opcode maps are disjoint, so one of them always rejects
    always_comb begin : chk_single_owner
        assert final (!(int_accept && bmu_accept))
            else $error("integer and Zbb decoders both accepted one word");
    end

endmodule

// File: design/address_stage.sv
`timescale 1ns/1ps
`include "apogeo_params.svh"

module address_stage import apogeo_pkg::*; (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           flush_i,
    input  logic           valid_i,
    input  data_word_t     pc_i,
    input  decode_packet_t packet_i,
    output issue_packet_t  issue_o,
    output logic           issue_valid_o
);

    data_word_t target;
    data_word_t link;

    // JALR passes its raw offset on, rs1 is added after register read
    assign target = packet_i.base_address_reg ? packet_i.address_offset
                                              : pc_i + packet_i.address_offset;

    // Return address for JAL and JALR, zero for everything else
    assign link = packet_i.save_next_pc ? pc_i + data_word_t'(`LINK_OFFSET) : '0;

    // Flush drops whatever is accepted on the same edge
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            issue_valid_o <= 1'b0;
        end else begin
            issue_valid_o <= valid_i & ~flush_i;
        end
    end

    // The packet holds until the next accepted instruction
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            issue_o <= '0;
        end else if (valid_i) begin
            issue_o.decode <= packet_i;
            issue_o.pc     <= pc_i;
            issue_o.target <= target;
            issue_o.link   <= link;
        end
    end

    // Nothing issues in the cycle that follows a flush
    property p_flush_kills_issue;
        @(posedge clk_i) disable iff (!rst_n_i) flush_i |=> !issue_valid_o;
    endproperty

    chk_flush : assert property (p_flush_kills_issue)
        else $error("issue valid high on the cycle after a flush");

endmodule

// File: design/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import apogeo_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          flush_i,
    input  logic          instr_valid_i,
    input  data_word_t    instr_i,
    input  data_word_t    instr_address_i,
    input  logic          priv_level_i,
    output issue_packet_t issue_o,
    output logic          issue_valid_o
);

    decode_packet_t dec_packet;

    // Decode is combinational, the word is resolved in its fetch cycle
    decoder u_decoder (
        .instr_i      ( instr_i      ),
        .priv_level_i ( priv_level_i ),
        .packet_o     ( dec_packet   )
    );

    // The pc and strobe bypass the decoder and meet the packet here
    address_stage u_address_stage (
        .clk_i         ( clk_i           ),
        .rst_n_i       ( rst_n_i         ),
        .flush_i       ( flush_i         ),
        .valid_i       ( instr_valid_i   ),
        .pc_i          ( instr_address_i ),
        .packet_i      ( dec_packet      ),
        .issue_o       ( issue_o         ),
        .issue_valid_o ( issue_valid_o   )
    );

endmodule

// File: tests/tb_decode_unit.sv
`timescale 1ns/1ps

module tb_decode_unit import apogeo_pkg::*;;

    // ==============================
    // DUT signals and clock
    // ==============================

    logic          clk_i;
    logic          rst_n_i;
    logic          flush_i;
    logic          instr_valid_i;
    data_word_t    instr_i;
    data_word_t    instr_address_i;
    logic          priv_level_i;
    issue_packet_t issue_o;
    logic          issue_valid_o;

    // Columns of the stimulus file, one entry per instruction
    logic [31:0] v_instr [64];
    logic [31:0] v_pc [64];
    logic [31:0] v_priv [64];
    logic [31:0] v_valid [64];
    logic [31:0] v_uop [64];
    logic [31:0] v_exc [64];
    logic [31:0] v_vec [64];
    logic [31:0] v_imm [64];
    logic [31:0] v_target [64];
    logic [31:0] v_link [64];

    int test_errors = 0;
    int pass_count = 0;
    int fail_count = 0;

    decode_unit DUT (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .flush_i         ( flush_i         ),
        .instr_valid_i   ( instr_valid_i   ),
        .instr_i         ( instr_i         ),
        .instr_address_i ( instr_address_i ),
        .priv_level_i    ( priv_level_i    ),
        .issue_o         ( issue_o         ),
        .issue_valid_o   ( issue_valid_o   )
    );

    always #2 clk_i = ~clk_i;

    // ==============================
    // Compare tasks
    // ==============================

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_valid(input exu_valid_t got, input exu_valid_t exp);
        if (got !== exp) begin
            $display("Fail exu_valid: got %h expected %h", got, exp);
            test_errors++;
        end
    endtask

    task automatic check_uop(input exu_uop_t got, input exu_uop_t exp);
        if (got !== exp) begin
            $display("Fail exu_uop: got %h expected %h", got, exp);
            test_errors++;
        end
    endtask

    task automatic check_word(input string name, input data_word_t got, input data_word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    // Flag and vector are reported together as flag_vector
    task automatic check_exc(input logic got_flag, input logic [4:0] got_vec,
                             input logic exp_flag, input logic [4:0] exp_vec);
        if (got_flag !== exp_flag || got_vec !== exp_vec) begin
            $display("Fail exception: got %h_%h expected %h_%h",
                     got_flag, got_vec, exp_flag, exp_vec);
            test_errors++;
        end
    endtask

    // Closes one test with its own report line
    task automatic close_test(input string label);
        if (test_errors == 0) begin
            pass_count++;
            $display("%s: ok", label);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", label, test_errors);
        end
        test_errors = 0;
    endtask

    // ==============================
    // Drive and wait
    // ==============================

    task automatic drive_vector(input int k);
        instr_i         = v_instr[k];
        instr_address_i = v_pc[k];
        priv_level_i    = v_priv[k][0];
        instr_valid_i   = 1'b1;
    endtask

    // Returns the edges counted up to and including the one that raised issue valid
    task automatic wait_issue(output int cycles);
        cycles = 0;
        do begin
            @(posedge clk_i);
            #1;
            cycles++;
        end while (!issue_valid_o && cycles < 20);
        if (!issue_valid_o) begin
            $display("Timed out after 20 cycles waiting for issue valid");
            test_errors++;
        end
    endtask

    task automatic check_vector(input int k, input int cycles);
        if (cycles != 1) begin
            $display("Instruction issued %0d cycles after acceptance instead of 1", cycles);
            test_errors++;
        end
        check_word("pc", issue_o.pc, v_pc[k]);
        check_valid(issue_o.decode.exu_valid, exu_valid_t'(v_valid[k][6:0]));
        check_uop(issue_o.decode.exu_uop, exu_uop_t'(v_uop[k][8:0]));
        check_exc(issue_o.decode.exception_generated, issue_o.decode.exception_vector,
                  v_exc[k][0], v_vec[k][4:0]);
        check_word("immediate[0]", issue_o.decode.immediate[0], v_imm[k]);
        check_word("target", issue_o.target, v_target[k]);
        check_word("link", issue_o.link, v_link[k]);
        // Zbb words never carry a second immediate
        if (v_valid[k][5]) begin
            check_word("immediate[1]", issue_o.decode.immediate[1], '0);
        end
        close_test($sformatf("test %0d instr %h", k, v_instr[k]));
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        int    fd;
        int    n;
        int    cycles;
        string line;

        clk_i           = 1'b0;
        rst_n_i         = 1'b0;
        flush_i         = 1'b0;
        instr_valid_i   = 1'b0;
        instr_i         = '0;
        instr_address_i = '0;
        priv_level_i    = 1'b0;
        n               = 0;

        fd = $fopen("tests/decode_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            test_errors++;
        end else begin
            while (!$feof(fd) && n < 64) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h", v_instr[n], v_pc[n],
                            v_priv[n], v_valid[n], v_uop[n], v_exc[n], v_vec[n], v_imm[n],
                            v_target[n], v_link[n]) == 10) begin
                    n++;
                end
            end
            $fclose(fd);
            if (n == 0) begin
                $display("The stimulus file holds no instructions");
                test_errors++;
            end
        end

        // Reset held for four edges, the stage must come out empty
        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        @(posedge clk_i);
        #1;
        check_bit("issue_valid_o", issue_valid_o, 1'b0);
        if (issue_o !== '0) begin
            $display("Issue packet is not zero after reset");
            test_errors++;
        end
        close_test("reset");

        // Every instruction streams back to back behind the previous one
        if (n > 0) begin
            drive_vector(0);
        end
        for (int k = 0; k < n; k++) begin
            wait_issue(cycles);
            if (k + 1 < n) begin
                drive_vector(k + 1);
            end else begin
                instr_valid_i = 1'b0;
            end
            check_vector(k, cycles);
        end

        // A flush on the accepting edge wins over the strobe
        if (n > 0) begin
            drive_vector(0);
            flush_i = 1'b1;
            @(posedge clk_i);
            #1;
            flush_i       = 1'b0;
            instr_valid_i = 1'b0;
            check_bit("issue_valid_o", issue_valid_o, 1'b0);
            close_test("flush");

            // The stage issues normally again once the flush is gone
            drive_vector(0);
            wait_issue(cycles);
            instr_valid_i = 1'b0;
            check_vector(0, cycles);
        end

        $display("%0d tests, %0d passed, %0d failed",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: tests/decode_stimulus.txt
# instr pc priv exu_valid uop exc vector imm0 target link, all in hex
# exu_valid is {alu,bmu,load,store,branch,jump,csr} and uop is {alu_op,bmu_op,csr_op}
002081b3 00001000 0 40 000 0 00 00000000 00001000 00000000
402081b3 00001004 0 40 020 0 00 00000000 00001004 00000000
407352b3 00001008 0 40 0e0 0 00 00000000 00001008 00000000
003130b3 0000100c 0 40 080 0 00 00000000 0000100c 00000000
fff10093 00001010 0 40 000 0 00 ffffffff 00001010 00000000
1232c213 00001014 0 40 0a0 0 00 00000123 00001014 00000000
4033d313 00001018 0 40 0e0 0 00 00000003 00001018 00000000
123452b7 0000101c 0 40 000 0 00 12345000 0000101c 00000000
00001297 00001020 0 40 000 0 00 00001000 00002020 00000000
00812083 00001024 0 10 000 0 00 00000008 00001024 00000000
00312623 00001028 0 08 000 0 00 00000000 00001028 00000000
00208863 0000102c 0 04 000 0 00 00000000 0000103c 00000000
fe209ce3 00001030 0 04 000 0 00 00000000 00001028 00000000
001000ef 00001034 0 02 000 0 00 00000000 00001834 00001038
ffdff06f 00001038 0 02 000 0 00 00000000 00001034 0000103c
010280e7 0000103c 0 02 000 0 00 00000000 00000010 00001040
300022f3 00001040 0 01 001 0 00 00000300 00001040 00000000
30531073 00001044 0 01 000 0 00 00000305 00001044 00000000
0ff0000f 00001048 0 00 000 0 00 00000000 00001048 00000000
00000073 0000104c 0 40 000 1 08 00000000 0000104c 00000000
00000073 00001050 1 40 000 1 0b 00000000 00001050 00000000
0000007f 00001054 0 40 000 1 02 00000000 00001054 00000000
022081b3 00001058 0 40 000 1 02 00000000 00001058 00000000
4020f1b3 0000105c 0 20 000 0 00 00000000 0000105c 00000000
4020c1b3 00001060 0 20 004 0 00 00000000 00001060 00000000
60031293 00001064 0 20 006 0 00 00000000 00001064 00000000
60231293 00001068 0 20 00a 0 00 00000000 00001068 00000000
0a20f1b3 0000106c 0 20 012 0 00 00000000 0000106c 00000000
0a20c1b3 00001070 0 20 00c 0 00 00000000 00001070 00000000
40309093 00001074 0 40 000 1 02 00000000 00001074 00000000

// File: tb.f
+incdir+design
design/apogeo_pkg.sv
design/integer_decoder.sv
design/bit_manipulation_decoder.sv
design/decoder.sv
design/address_stage.sv
design/decode_unit.sv
tests/tb_decode_unit.sv

// File: run.sh
#!/bin/sh
# Compile and run the decode unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_decode_unit -o sim_decode_unit
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_decode_unit)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '** PASS **'; then
    exit 0
fi
exit 1
